// File: build.f
+incdir+include
rtl/pwo_pkg.sv
rtl/pwo_mem.sv
rtl/pwo_reader.sv
rtl/pwo_fifo.sv
rtl/pwo_alu.sv
rtl/pwo_top.sv
verif/pwo_clk_gen.sv
verif/pwo_tb.sv

// File: verif/pwo_tb.sv
// ======================================================================
// Table entries run in order and share memory state between runs;
// stops at the first mismatch or when the cycle budget runs out
// ======================================================================
`include "pwo_defines.svh"

module pwo_tb;
    import pwo_pkg::*;

    localparam longint Q          = `PWO_Q;
    localparam int     WORDS      = `PWO_N / `PWO_LANES;
    localparam int     N_TESTS    = 6;
    localparam int     MAX_CYCLES = N_TESTS * (64 + 64 + 100 + 64) * 2;
    // Operand source for an entry
    localparam int     OPS_NONE   = 0;
    localparam int     OPS_RAND   = 1;
    localparam int     OPS_ZERO_B = 2;

    logic                   clk;
    logic                   rst_n;
    logic                   zeroize;
    logic                   start;
    pwo_mode_t              mode;
    logic                   accumulate;
    logic                   load_valid;
    pwo_sel_t               load_sel;
    logic [`PWO_ADDR_W-1:0] load_addr;
    pwo_word_u              load_data;
    logic                   res_rd_en;
    logic [`PWO_ADDR_W-1:0] res_rd_addr;
    logic                   load_ready;
    pwo_word_u              res_rd_data;
    logic                   done;

    // ==================================================================
    // Stimulus table of name, mode, accumulate, zeroize first, operands
    // and load attempt during the run
    // ==================================================================
    string     t_name  [N_TESTS];
    pwo_mode_t t_mode  [N_TESTS];
    logic      t_acc   [N_TESTS];
    logic      t_zero  [N_TESTS];
    int        t_ops   [N_TESTS];
    logic      t_probe [N_TESTS];

    // Expected contents of A, B and C
    longint      a_mdl [`PWO_N];
    longint      b_mdl [`PWO_N];
    longint      c_mdl [`PWO_N];
    logic [31:0] rng_state;
    int          cycle_cnt = 0;
    int          done_cnt = 0;
    int          run_cnt = 0;

    pwo_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    pwo_top DUT (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize), .start(start), .mode(mode),
        .accumulate(accumulate), .load_valid(load_valid), .load_sel(load_sel),
        .load_addr(load_addr), .load_data(load_data), .res_rd_en(res_rd_en),
        .res_rd_addr(res_rd_addr), .load_ready(load_ready),
        .res_rd_data(res_rd_data), .done(done)
    );

    // Cycle budget and done pulse count
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (rst_n && done) begin
            done_cnt <= done_cnt + 1;
        end
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("ERROR: run timed out after %0d cycles", cycle_cnt);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected coefficient straight from the mod q rules
    function automatic longint expect_coef(input pwo_mode_t m, input logic acc,
                                           input longint a, input longint b,
                                           input longint c_old);
        longint r;
        case (m)
            PWA:     r = (a + b) % Q;
            PWS:     r = (a - b + Q) % Q;
            default: r = (a * b) % Q;
        endcase
        if (acc) begin
            r = (r + c_old) % Q;
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Inputs change one unit after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic set_entry(input int i, input string name, input pwo_mode_t m,
                             input logic acc, input logic zero, input int ops,
                             input logic probe);
        t_name[i]  = name;
        t_mode[i]  = m;
        t_acc[i]   = acc;
        t_zero[i]  = zero;
        t_ops[i]   = ops;
        t_probe[i] = probe;
    endtask

    task automatic gen_operands();
        for (int i = 0; i < `PWO_N; i++) begin
            rng_state = xorshift32(rng_state);
            a_mdl[i]  = rng_state % Q;
            rng_state = xorshift32(rng_state);
            b_mdl[i]  = rng_state % Q;
            // Reduction extremes every 16 coefficients
            case (i % 16)
                0: a_mdl[i] = Q - 1;
                1: b_mdl[i] = Q - 1;
                2: begin
                    a_mdl[i] = Q - 1;
                    b_mdl[i] = Q - 1;
                end
                3: a_mdl[i] = 0;
                default: begin
                end
            endcase
        end
    endtask

    // Zeroize sweep of one word per cycle
    task automatic clear_all(input string name);
        zeroize = 1'b1;
        for (int w = 0; w < WORDS; w++) begin
            step();
            check_val({name, " load_ready in zeroize"}, 0, load_ready);
        end
        zeroize = 1'b0;
        for (int i = 0; i < `PWO_N; i++) begin
            a_mdl[i] = 0;
            b_mdl[i] = 0;
            c_mdl[i] = 0;
        end
    endtask

    task automatic load_poly(input pwo_sel_t sel);
        logic ready_seen;
        for (int w = 0; w < WORDS; w++) begin
            load_valid = 1'b1;
            load_sel   = sel;
            load_addr  = `PWO_ADDR_W'(w);
            for (int l = 0; l < `PWO_LANES; l++) begin
                load_data.lane[l] = (sel == SEL_A) ? `PWO_REG_SIZE'(a_mdl[w * `PWO_LANES + l])
                                                   : `PWO_REG_SIZE'(b_mdl[w * `PWO_LANES + l]);
            end
            // Beat moves on an edge where ready was high at mid-cycle
            do begin
                #2;
                ready_seen = load_ready;
                step();
            end while (!ready_seen);
        end
        load_valid = 1'b0;
    endtask

    task automatic run_op(input int t);
        start      = 1'b1;
        mode       = t_mode[t];
        accumulate = t_acc[t];
        step();
        start   = 1'b0;
        run_cnt = run_cnt + 1;
        if (t_probe[t]) begin
            // Out-of-range word aimed at A that must never be taken
            load_valid    = 1'b1;
            load_sel      = SEL_A;
            load_addr     = '0;
            load_data.raw = '1;
        end
        do begin
            step();
            if (t_probe[t]) begin
                check_val({t_name[t], " load_ready while busy"}, 0, load_ready);
            end
        end while (!done);
        load_valid = 1'b0;
    endtask

    task automatic read_check(input int t);
        for (int i = 0; i < `PWO_N; i++) begin
            c_mdl[i] = expect_coef(t_mode[t], t_acc[t], a_mdl[i], b_mdl[i], c_mdl[i]);
        end
        for (int w = 0; w < WORDS; w++) begin
            res_rd_en   = 1'b1;
            res_rd_addr = `PWO_ADDR_W'(w);
            step();
            for (int l = 0; l < `PWO_LANES; l++) begin
                check_val($sformatf("%s c[%0d]", t_name[t], w * `PWO_LANES + l),
                          c_mdl[w * `PWO_LANES + l], res_rd_data.lane[l]);
            end
        end
        res_rd_en = 1'b0;
        // Exactly one done per start so far
        check_val({t_name[t], " done count"}, run_cnt, done_cnt);
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        zeroize     = 1'b0;
        start       = 1'b0;
        mode        = PWA;
        accumulate  = 1'b0;
        load_valid  = 1'b0;
        load_sel    = SEL_A;
        load_addr   = '0;
        load_data   = '0;
        res_rd_en   = 1'b0;
        res_rd_addr = '0;
        rng_state   = 32'h0e3498f6;
        set_entry(0, "pwa", PWA, 1'b0, 1'b1, OPS_RAND, 1'b0);
        set_entry(1, "pws", PWS, 1'b0, 1'b1, OPS_RAND, 1'b0);
        set_entry(2, "pwm", PWM, 1'b0, 1'b1, OPS_RAND, 1'b0);
        // New operands over the previous product with a blocked load
        set_entry(3, "pwm_acc", PWM, 1'b1, 1'b0, OPS_RAND, 1'b1);
        // A survives the blocked load and B is cleared so C mirrors A
        set_entry(4, "a_kept", PWA, 1'b0, 1'b0, OPS_ZERO_B, 1'b0);
        // Accumulate exposes any C word the sweep missed
        set_entry(5, "zeroize", PWA, 1'b1, 1'b1, OPS_NONE, 1'b0);
        @(posedge rst_n);
        step();
        for (int t = 0; t < N_TESTS; t++) begin
            if (t_zero[t]) begin
                clear_all(t_name[t]);
            end
            case (t_ops[t])
                OPS_RAND: begin
                    gen_operands();
                    load_poly(SEL_A);
                    load_poly(SEL_B);
                end
                OPS_ZERO_B: begin
                    for (int i = 0; i < `PWO_N; i++) begin
                        b_mdl[i] = 0;
                    end
                    load_poly(SEL_B);
                end
                default: begin
                end
            endcase
            run_op(t);
            read_check(t);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: verif/pwo_clk_gen.sv
// ======================================================================
// Free-running clock of period 4; rst_n held low for 8 rising edges
// ======================================================================

module pwo_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Release one unit after an edge, away from the sampling point
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: rtl/pwo_top.sv
// ======================================================================
// Zeroize and start are only legal while idle; result reads are
// meaningful once done has pulsed
// ======================================================================
`include "pwo_defines.svh"

module pwo_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  zeroize,
    input  logic                  start,
    input  pwo_pkg::pwo_mode_t    mode,
    input  logic                  accumulate,
    input  logic                  load_valid,
    input  pwo_pkg::pwo_sel_t     load_sel,
    input  logic [`PWO_ADDR_W-1:0] load_addr,
    input  pwo_pkg::pwo_word_u    load_data,
    input  logic                  res_rd_en,
    input  logic [`PWO_ADDR_W-1:0] res_rd_addr,
    output logic                  load_ready,
    output pwo_pkg::pwo_word_u    res_rd_data,
    output logic                  done
);
    import pwo_pkg::*;

    // Reader and A/B memories
    logic                   a_wr_en;
    logic                   b_wr_en;
    logic [`PWO_ADDR_W-1:0] mem_wr_addr;
    pwo_word_u              mem_wr_data;
    logic                   rd_en;
    logic [`PWO_ADDR_W-1:0] rd_addr;
    pwo_word_u              a_rd_data;
    pwo_word_u              b_rd_data;

    // Reader to FIFO
    logic                   op_valid;
    logic                   op_ready;
    pwo_word_u              op_a;
    pwo_word_u              op_b;
    logic [$clog2(`PWO_FIFO_DEPTH+1)-1:0] fifo_count;

    // FIFO to ALU
    logic                   pair_valid;
    logic                   pair_ready;
    pwo_word_u              pair_a;
    pwo_word_u              pair_b;

    // ALU and C memory
    logic                   c_rd_en;
    logic [`PWO_ADDR_W-1:0] c_rd_addr;
    pwo_word_u              c_rd_data;
    logic                   c_wr_en;
    logic [`PWO_ADDR_W-1:0] c_wr_addr;
    pwo_word_u              c_wr_data;

    // ==================================================================
    // Memories with the second read port used only on C
    // ==================================================================
    pwo_mem mem_a (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
        .wr_en(a_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
        .rd0_en(rd_en), .rd0_addr(rd_addr), .rd0_data(a_rd_data),
        .rd1_en(1'b0), .rd1_addr('0), .rd1_data()
    );

    pwo_mem mem_b (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
        .wr_en(b_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
        .rd0_en(rd_en), .rd0_addr(rd_addr), .rd0_data(b_rd_data),
        .rd1_en(1'b0), .rd1_addr('0), .rd1_data()
    );

    pwo_mem mem_c (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
        .wr_en(c_wr_en), .wr_addr(c_wr_addr), .wr_data(c_wr_data),
        .rd0_en(c_rd_en), .rd0_addr(c_rd_addr), .rd0_data(c_rd_data),
        .rd1_en(res_rd_en), .rd1_addr(res_rd_addr), .rd1_data(res_rd_data)
    );

    // ==================================================================
    // Producer, buffer, consumer
    // ==================================================================
    pwo_reader u_reader (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize), .start(start), .done(done),
        .load_valid(load_valid), .load_sel(load_sel), .load_addr(load_addr),
        .load_data(load_data), .a_rd_data(a_rd_data), .b_rd_data(b_rd_data),
        .op_ready(op_ready), .fifo_count(fifo_count), .load_ready(load_ready),
        .busy(), .a_wr_en(a_wr_en), .b_wr_en(b_wr_en),
        .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data),
        .rd_en(rd_en), .rd_addr(rd_addr),
        .op_valid(op_valid), .op_a(op_a), .op_b(op_b)
    );

    pwo_fifo u_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_valid(op_valid), .in_a(op_a), .in_b(op_b), .in_ready(op_ready),
        .out_ready(pair_ready), .out_valid(pair_valid),
        .out_a(pair_a), .out_b(pair_b), .count(fifo_count)
    );

    pwo_alu u_alu (
        .clk(clk), .rst_n(rst_n), .start(start), .mode(mode),
        .accumulate(accumulate), .in_valid(pair_valid), .in_a(pair_a),
        .in_b(pair_b), .c_rd_data(c_rd_data), .in_ready(pair_ready),
        .c_rd_en(c_rd_en), .c_rd_addr(c_rd_addr), .c_wr_en(c_wr_en),
        .c_wr_addr(c_wr_addr), .c_wr_data(c_wr_data), .done(done)
    );

endmodule

// File: rtl/pwo_alu.sv
// ======================================================================
// Operands must already be below q; old C is only meaningful for
// accumulate after a zeroize or an earlier run
// ======================================================================
`include "pwo_defines.svh"

module pwo_alu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  pwo_pkg::pwo_mode_t    mode,
    input  logic                  accumulate,
    input  logic                  in_valid,
    input  pwo_pkg::pwo_word_u    in_a,
    input  pwo_pkg::pwo_word_u    in_b,
    input  pwo_pkg::pwo_word_u    c_rd_data,
    output logic                  in_ready,
    output logic                  c_rd_en,
    output logic [`PWO_ADDR_W-1:0] c_rd_addr,
    output logic                  c_wr_en,
    output logic [`PWO_ADDR_W-1:0] c_wr_addr,
    output pwo_pkg::pwo_word_u    c_wr_data,
    output logic                  done
);
    import pwo_pkg::*;

    localparam int LANES = `PWO_LANES;
    // Reduced coefficient and full product widths
    localparam int CW = `PWO_REG_SIZE - 1;
    localparam int PW = 2 * CW;

    logic                          run;
    pwo_mode_t                     mode_q;
    logic                          acc_q;
    logic                          pop;
    logic [`PWO_ADDR_W-1:0]        pop_cnt;
    logic [LANES-1:0][PW-1:0]      raw_d;
    logic [LANES-1:0][PW-1:0]      s1_raw;
    logic                          s1_valid;
    logic [`PWO_ADDR_W-1:0]        s1_addr;
    logic [LANES-1:0][CW-1:0]      red;
    pwo_word_u                     wr_d;

    // Single correction, input below 2q
    function automatic logic [CW-1:0] cond_sub(input logic [CW:0] x);
        return (x >= `PWO_Q) ? CW'(x - `PWO_Q) : x[CW-1:0];
    endfunction

    // Fold with 2^23 = 2^13 - 1 mod q, three times, then correct
    function automatic logic [CW-1:0] mul_red(input logic [PW-1:0] p);
        logic [37:0] r1;
        logic [27:0] r2;
        logic [23:0] r3;
        r1 = {p[45:23], 13'b0} + p[22:0] - p[45:23];
        r2 = {r1[37:23], 13'b0} + r1[22:0] - r1[37:23];
        r3 = {r2[27:23], 13'b0} + r2[22:0] - r2[27:23];
        return cond_sub(r3);
    endfunction

    function automatic logic lanes_below_q(input pwo_word_u w);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < LANES; i++) begin
            ok &= (w.lane[i] < `PWO_Q);
        end
        return ok;
    endfunction

    // ==================================================================
    // Pop and old C read
    // ==================================================================
    assign in_ready  = run;
    assign pop       = in_valid && in_ready;
    assign c_rd_en   = pop;
    assign c_rd_addr = pop_cnt;

    // Stage 1 raw operation, subtract biased by q to stay positive
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            case (mode_q)
                PWA:     raw_d[i] = in_a.lane[i] + in_b.lane[i];
                PWS:     raw_d[i] = in_a.lane[i] + `PWO_Q - in_b.lane[i];
                default: raw_d[i] = in_a.lane[i][CW-1:0] * in_b.lane[i][CW-1:0];
            endcase
        end
    end

    // Stage 2 reduction; old C arrives from the RAM this cycle
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (mode_q == PWM) begin
                red[i] = mul_red(s1_raw[i]);
            end else begin
                red[i] = cond_sub(s1_raw[i][CW:0]);
            end
            if (acc_q) begin
                wr_d.lane[i] = {1'b0, cond_sub({1'b0, red[i]} + c_rd_data.lane[i][CW-1:0])};
            end else begin
                wr_d.lane[i] = {1'b0, red[i]};
            end
        end
    end

    // ==================================================================
    // Control
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run      <= 1'b0;
            mode_q   <= PWM;
            acc_q    <= 1'b0;
            pop_cnt  <= '0;
            s1_valid <= 1'b0;
            c_wr_en  <= 1'b0;
            done     <= 1'b0;
        end else begin
            if (start && !run) begin
                run     <= 1'b1;
                mode_q  <= mode;
                acc_q   <= accumulate;
                pop_cnt <= '0;
            end else if (done) begin
                run <= 1'b0;
            end
            if (pop) begin
                pop_cnt <= pop_cnt + 1'b1;
            end
            s1_valid <= pop;
            c_wr_en  <= s1_valid;
            // Word 63 lands at this edge
            done     <= c_wr_en && (&c_wr_addr);
        end
    end

    // Pipeline payload
    always_ff @(posedge clk) begin
        if (pop) begin
            s1_raw  <= raw_d;
            s1_addr <= pop_cnt;
        end
        if (s1_valid) begin
            c_wr_addr <= s1_addr;
            c_wr_data <= wr_d;
        end
    end

    // Holds only while loaded operands and old C are reduced
    a_wr_below_q: assert property (
        @(posedge clk) disable iff (!rst_n) c_wr_en |-> lanes_below_q(c_wr_data)
    );

endmodule

// File: rtl/pwo_fifo.sv
// ======================================================================
// Operand pair buffer; output is registered storage, visible the
// cycle after the push
// ======================================================================
`include "pwo_defines.svh"

module pwo_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  pwo_pkg::pwo_word_u in_a,
    input  pwo_pkg::pwo_word_u in_b,
    input  logic               out_ready,
    output logic               in_ready,
    output logic               out_valid,
    output pwo_pkg::pwo_word_u out_a,
    output pwo_pkg::pwo_word_u out_b,
    output logic [$clog2(`PWO_FIFO_DEPTH+1)-1:0] count
);
    import pwo_pkg::*;

    localparam int DEPTH = `PWO_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    pwo_word_u        buf_a [DEPTH];
    pwo_word_u        buf_b [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             pop;

    assign in_ready  = (count != DEPTH);
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_a     = buf_a[rd_ptr];
    assign out_b     = buf_b[rd_ptr];

    // Pointers wrap on their own width
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_a[wr_ptr] <= in_a;
            buf_b[wr_ptr] <= in_b;
        end
    end

    // Producer never offers a word to a full buffer
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) in_valid |-> in_ready
    );

    // A pop must find a written entry between the pointers
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> (wr_ptr != rd_ptr) || (count == DEPTH)
    );

endmodule

// File: rtl/pwo_reader.sv
// ======================================================================
// Loads are taken only when idle; a run reads all 64 A/B words in
// order, never issuing more reads than the FIFO has free slots
// ======================================================================
`include "pwo_defines.svh"

module pwo_reader (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  zeroize,
    input  logic                  start,
    input  logic                  done,
    input  logic                  load_valid,
    input  pwo_pkg::pwo_sel_t     load_sel,
    input  logic [`PWO_ADDR_W-1:0] load_addr,
    input  pwo_pkg::pwo_word_u    load_data,
    input  pwo_pkg::pwo_word_u    a_rd_data,
    input  pwo_pkg::pwo_word_u    b_rd_data,
    input  logic                  op_ready,
    input  logic [$clog2(`PWO_FIFO_DEPTH+1)-1:0] fifo_count,
    output logic                  load_ready,
    output logic                  busy,
    output logic                  a_wr_en,
    output logic                  b_wr_en,
    output logic [`PWO_ADDR_W-1:0] mem_wr_addr,
    output pwo_pkg::pwo_word_u    mem_wr_data,
    output logic                  rd_en,
    output logic [`PWO_ADDR_W-1:0] rd_addr,
    output logic                  op_valid,
    output pwo_pkg::pwo_word_u    op_a,
    output pwo_pkg::pwo_word_u    op_b
);
    import pwo_pkg::*;

    // Still walking addresses
    logic issuing;
    logic credit_ok;
    logic load_fire;

    // ==================================================================
    // Host load decode
    // ==================================================================
    assign load_ready  = !busy && !zeroize;
    assign load_fire   = load_valid && load_ready;
    assign a_wr_en     = load_fire && (load_sel == SEL_A);
    assign b_wr_en     = load_fire && (load_sel == SEL_B);
    assign mem_wr_addr = load_addr;
    assign mem_wr_data = load_data;

    // ==================================================================
    // Run sequencing
    // ==================================================================
    // Occupied slots plus the read whose data lands this cycle
    assign credit_ok = (int'(fifo_count) + int'(op_valid)) < `PWO_FIFO_DEPTH;
    assign rd_en     = issuing && credit_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            issuing  <= 1'b0;
            rd_addr  <= '0;
            op_valid <= 1'b0;
        end else begin
            if (start && !busy) begin
                busy    <= 1'b1;
                issuing <= 1'b1;
                rd_addr <= '0;
            end else if (done) begin
                busy <= 1'b0;
            end
            if (rd_en) begin
                rd_addr <= rd_addr + 1'b1;
                // Last word issued
                if (&rd_addr) begin
                    issuing <= 1'b0;
                end
            end
            // RAM data returns one cycle after the read
            op_valid <= rd_en;
        end
    end

    assign op_a = a_rd_data;
    assign op_b = b_rd_data;

    // Credit accounting must keep the FIFO from ever refusing a push
    a_credit_safe: assert property (
        @(posedge clk) disable iff (!rst_n) op_valid |-> op_ready
    );

endmodule

// File: rtl/pwo_mem.sv
// ======================================================================
// One write and two registered read ports; contents are undefined
// until a full zeroize sweep of 64 cycles has run
// ======================================================================
`include "pwo_defines.svh"

module pwo_mem (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  zeroize,
    input  logic                  wr_en,
    input  logic [`PWO_ADDR_W-1:0] wr_addr,
    input  pwo_pkg::pwo_word_u    wr_data,
    input  logic                  rd0_en,
    input  logic [`PWO_ADDR_W-1:0] rd0_addr,
    input  logic                  rd1_en,
    input  logic [`PWO_ADDR_W-1:0] rd1_addr,
    output pwo_pkg::pwo_word_u    rd0_data,
    output pwo_pkg::pwo_word_u    rd1_data
);

    localparam int WORDS = `PWO_N / `PWO_LANES;

    logic [`PWO_WORD_W-1:0] mem [WORDS];
    // Sweep pointer, one word cleared per cycle
    logic [`PWO_ADDR_W-1:0] zero_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            zero_addr <= '0;
        end else if (zeroize) begin
            zero_addr <= zero_addr + 1'b1;
        end else begin
            zero_addr <= '0;
        end
    end

    // Zeroize owns the write port while it is high
    always_ff @(posedge clk) begin
        if (zeroize) begin
            mem[zero_addr] <= '0;
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data.raw;
        end
        if (rd0_en) begin
            rd0_data.raw <= mem[rd0_addr];
        end
        if (rd1_en) begin
            rd1_data.raw <= mem[rd1_addr];
        end
    end

    // Host and ALU must hold off writes for the whole sweep
    a_no_wr_in_zeroize: assert property (
        @(posedge clk) disable iff (!rst_n) zeroize |-> !wr_en
    );

endmodule

// File: rtl/pwo_pkg.sv
// ======================================================================
// Shared types; lane 0 sits in the low bits of a memory word
// ======================================================================
`include "pwo_defines.svh"

package pwo_pkg;

    // Point-wise operation selected at start
    typedef enum logic [1:0] {
        PWM = 2'd0,
        PWA = 2'd1,
        PWS = 2'd2
    } pwo_mode_t;

    // Host load target
    typedef enum logic {
        SEL_A = 1'b0,
        SEL_B = 1'b1
    } pwo_sel_t;

    // Stored as a flat word, computed per coefficient
    typedef union packed {
        logic [`PWO_WORD_W-1:0] raw;
        logic [`PWO_LANES-1:0][`PWO_REG_SIZE-1:0] lane;
    } pwo_word_u;

endpackage

// File: include/pwo_defines.svh
// ======================================================================
// Sizing for the point-wise engine; q must stay below 2^23 for the
// folded reduction, and the FIFO depth must be a power of two
// ======================================================================
`ifndef PWO_DEFINES_SVH
`define PWO_DEFINES_SVH

// Bits per stored coefficient
`define PWO_REG_SIZE 24

// Dilithium modulus, 2^23 - 2^13 + 1
`define PWO_Q 23'd8380417

// Coefficients per polynomial
`define PWO_N 256

// Coefficients packed in one memory word
`define PWO_LANES 4
`define PWO_WORD_W 96

// 64 words per polynomial
`define PWO_ADDR_W 6

// Operand pair buffer entries
`define PWO_FIFO_DEPTH 4

`endif
